//--- Makefile
TOP = tb_adc_scope

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verif/tb_adc_scope.sv
`timescale 1ns/1ns

module tb_adc_scope;

   import scope_pkg::*;

   localparam int MAX_CYCLES = 4000;   // about 1700 used, leaves margin

   logic          clk_usb;
   logic          reset;
   scope_cfg_t    cfg;
   board_status_t status;
   adc_word_t     adc_data;
   logic          dut_clk;
   logic          led_armed, led_capture, freq_measure, flash_pattern;
   logic          trigger_adc, amp_gain, extclk_change;
   freq_count_t   extclk_freq;

   int        cycle;
   int        last_strobe;
   int        strobe_count;
   int        trig_count;
   int        dut_half;      // dut_clk half period in clk_usb cycles
   int        dut_cnt;
   logic      strobe_d;
   logic      freq_check;
   logic      rand_on;
   logic      rand_check;
   adc_word_t hist [0:2];    // adc samples from the last three edges

   tb_clock tb_clock_inst (.clk_usb(clk_usb), .reset(reset));

   adc_scope_top adc_scope_top_inst (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .cfg_i            (cfg),
      .status_i         (status),
      .adc_data_i       (adc_data),
      .dut_clk_i        (dut_clk),
      .led_armed_o      (led_armed),
      .led_capture_o    (led_capture),
      .freq_measure_o   (freq_measure),
      .flash_pattern_o  (flash_pattern),
      .trigger_adc_o    (trigger_adc),
      .amp_gain_o       (amp_gain),
      .extclk_freq_o    (extclk_freq),
      .extclk_change_o  (extclk_change)
   );

   task automatic report_failure(input string what);
      $display("Errors found");
      $fatal(1, "%s", what);
   endtask

   task automatic step(input int n);
      repeat (n) @(posedge clk_usb);
      #1;
   endtask

   task automatic wait_strobes(input int n);
      int target;
      target = strobe_count + n;
      while (strobe_count < target)
         step(1);
   endtask

   // waits for the trigger count to move, at most one ramp period
   task automatic wait_trigger(input int base);
      int i;
      i = 0;
      while (trig_count == base && i < 4096) begin
         step(1);
         i++;
      end
   endtask

   // target clock, changes 1 ns after the edge
   always @(posedge clk_usb) begin
      #1;
      if (dut_cnt >= dut_half - 1) begin
         dut_cnt = 0;
         dut_clk = ~dut_clk;
      end
      else
         dut_cnt = dut_cnt + 1;
      if (rand_on)
         adc_data = adc_word_t'($urandom);
   end

   strobe_one_cycle: assert property (
      @(posedge clk_usb) disable iff (reset)
      freq_measure |=> !freq_measure
   ) else begin
      $display("ERR freq_measure_o high twice: %h", freq_measure);
      report_failure("strobe longer than one cycle");
   end

   always @(posedge clk_usb) begin
      cycle++;
      if (cycle > MAX_CYCLES)
         report_failure("timeout, run did not finish in time");
      if (!reset) begin
         if (freq_measure) begin
            if (last_strobe >= 0)
               assert (cycle - last_strobe == 64) else begin
                  $display("ERR freq_measure_o spacing %h", cycle - last_strobe);
                  report_failure("gate spacing wrong");
               end
            last_strobe = cycle;
            strobe_count++;
         end
         if (strobe_d && freq_check)
            assert (extclk_freq >= 15 && extclk_freq <= 17) else begin
               $display("ERR extclk_freq_o %h", extclk_freq);
               report_failure("frequency count wrong");
            end
         if (trigger_adc) begin
            trig_count++;
            if (rand_check)
               assert (hist[2] > cfg.trigger_level) else begin
                  $display("ERR trigger_adc_o %h sample %h level %h",
                           trigger_adc, hist[2], cfg.trigger_level);
                  report_failure("trigger pulse without level crossing");
               end
         end
         if (extclk_change)
            assert (led_armed == flash_pattern && led_capture == flash_pattern) else begin
               $display("ERR led_armed_o %h led_capture_o %h flash %h",
                        led_armed, led_capture, flash_pattern);
               report_failure("alarm flash not on leds");
            end
         else if (cfg.led_select == 2'd0)
            assert (led_armed == status.armed && led_capture == status.capture_active)
            else begin
               $display("ERR led_armed_o %h led_capture_o %h", led_armed, led_capture);
               report_failure("leds do not show status");
            end
         else if (cfg.led_select == 2'd3)
            assert (led_capture == 1'b0) else begin
               $display("ERR led_capture_o %h", led_capture);
               report_failure("alarm led lit without alarm");
            end
      end
      strobe_d = freq_measure;
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = adc_data;
   end

   // counts pwm carries over one full accumulator period
   task automatic check_gain(input gain_t g);
      int highs;
      cfg.gain = g;
      step(2);
      highs = 0;
      repeat (256) begin
         @(posedge clk_usb);
         if (amp_gain)
            highs++;
      end
      #1;
      assert (highs == g) else begin
         $display("ERR amp_gain_o count %h gain %h", highs, g);
         report_failure("pwm duty wrong");
      end
   endtask

   initial begin
      int base;
      void'($urandom(88));
      cycle = 0;
      last_strobe = -1;
      strobe_count = 0;
      trig_count = 0;
      dut_half = 2;
      dut_cnt = 0;
      dut_clk = 1'b0;
      strobe_d = 1'b0;
      freq_check = 1'b0;
      rand_on = 1'b0;
      rand_check = 1'b0;
      adc_data = '0;
      hist[0] = '0;
      hist[1] = '0;
      hist[2] = '0;
      status = '0;
      cfg = '0;
      cfg.extclk_limit = 16'd4;
      cfg.trigger_level = 12'h7ff;
      cfg.monitor_disable = 1'b1;   // first window after reset is partial
      @(negedge reset);

      // steady target clock, one edge per 4 cycles
      wait_strobes(3);
      freq_check = 1'b1;
      cfg.monitor_disable = 1'b0;
      wait_strobes(3);
      freq_check = 1'b0;
      assert (!extclk_change) else begin
         $display("ERR extclk_change_o %h", extclk_change);
         report_failure("alarm raised with a steady clock");
      end
      dut_half = 4;   // switch right after a gate
      wait_strobes(2);
      step(1);
      assert (extclk_change) else begin
         $display("ERR extclk_change_o %h", extclk_change);
         report_failure("alarm not raised after clock change");
      end
      cfg.monitor_disable = 1'b1;
      step(2);
      assert (!extclk_change) else begin
         $display("ERR extclk_change_o %h", extclk_change);
         report_failure("alarm not cleared by disable");
      end
      cfg.monitor_disable = 1'b0;

      // ramp source, one shot per arming edge
      base = trig_count;
      status.armed_and_ready = 1'b1;
      wait_trigger(base);
      step(300);
      assert (trig_count == base + 1) else begin
         $display("ERR trigger_adc_o pulses %h", trig_count - base);
         report_failure("wrong pulse count after first arming");
      end
      status.armed_and_ready = 1'b0;
      step(2);
      status.armed_and_ready = 1'b1;
      wait_trigger(base + 1);
      step(5);
      assert (trig_count == base + 2) else begin
         $display("ERR trigger_adc_o pulses %h", trig_count - base);
         report_failure("no pulse after re-arming");
      end

      // random adc data, level above mid scale
      status.armed_and_ready = 1'b0;
      cfg.trigger_level = 12'h900;
      cfg.data_source_select = 1'b1;
      rand_on = 1'b1;
      step(4);
      rand_check = 1'b1;
      repeat (10) begin
         status.armed_and_ready = 1'b0;
         step(3);
         status.armed_and_ready = 1'b1;
         step(20);
      end
      rand_check = 1'b0;
      rand_on = 1'b0;

      check_gain(8'h5a);
      check_gain(8'h03);

      // led selection
      cfg.led_select = 2'd0;
      repeat (4) begin
         status.armed = 1'($urandom);
         status.capture_active = 1'($urandom);
         step(2);
      end
      cfg.led_select = 2'd3;
      step(4);
      cfg.led_select = 2'd1;
      step(4);

      $display("No errors");
      $finish;
   end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
   output logic clk_usb,
   output logic reset
);

   initial begin
      clk_usb = 1'b0;
      forever #5 clk_usb = ~clk_usb;   // 10 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (4) @(posedge clk_usb);
      #1 reset = 1'b0;
   end

endmodule

//--- verilog.f
verilog/scope_pkg.sv
verilog/heartbeat_timer.sv
verilog/clk_freq_monitor.sv
verilog/adc_level_trigger.sv
verilog/board_outputs.sv
verilog/adc_scope_top.sv
verif/tb_clock.sv
verif/tb_adc_scope.sv

//--- verilog/adc_level_trigger.sv
`timescale 1ns/1ns

module adc_level_trigger (
   input  logic                 clk_usb,
   input  logic                 reset,
   input  scope_pkg::adc_word_t adc_data_i,
   input  logic                 data_source_select_i,
   input  scope_pkg::adc_word_t trigger_level_i,
   input  logic                 armed_and_ready_i,
   output logic                 trigger_adc_o
);

   import scope_pkg::*;

   adc_word_t ramp;           // test pattern
   adc_word_t sample_pre;
   adc_word_t sample_stage;   // compare stage
   logic      level_hit;
   logic      trigger_allowed;
   logic      armed_r;

   always_ff @(posedge clk_usb) begin
      if (reset)
         ramp <= '0;
      else
         ramp <= ramp + 1'b1;
   end

   // two stage resample
   always_ff @(posedge clk_usb) begin
      sample_pre   <= data_source_select_i ? adc_data_i : ramp;
      sample_stage <= sample_pre;
   end

   // msb of the level picks the direction
   assign level_hit = trigger_level_i[ADC_W-1] ? (sample_stage > trigger_level_i)
                                               : (sample_stage < trigger_level_i);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_r         <= 1'b0;
         trigger_allowed <= 1'b0;
         trigger_adc_o   <= 1'b0;
      end
      else begin
         armed_r       <= armed_and_ready_i;
         trigger_adc_o <= trigger_allowed & ~trigger_adc_o & level_hit;

         if (trigger_adc_o)
            trigger_allowed <= 1'b0;   // single shot
         else if (armed_and_ready_i && !armed_r)
            trigger_allowed <= 1'b1;
      end
   end

   trigger_single_cycle: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_adc_o |=> !trigger_adc_o
   ) else $error("ERR trigger_adc_o high for two cycles");

endmodule

//--- verilog/adc_scope_top.sv
`timescale 1ns/1ns

module adc_scope_top (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  scope_pkg::scope_cfg_t    cfg_i,
   input  scope_pkg::board_status_t status_i,
   input  scope_pkg::adc_word_t     adc_data_i,
   input  logic                     dut_clk_i,
   output logic                     led_armed_o,
   output logic                     led_capture_o,
   output logic                     freq_measure_o,
   output logic                     flash_pattern_o,
   output logic                     trigger_adc_o,
   output logic                     amp_gain_o,
   output scope_pkg::freq_count_t   extclk_freq_o,
   output logic                     extclk_change_o
);

   logic gate_strobe;
   logic heartbeat;
   logic flash_pattern;
   logic extclk_change;

   assign freq_measure_o  = gate_strobe;
   assign flash_pattern_o = flash_pattern;
   assign extclk_change_o = extclk_change;

   heartbeat_timer heartbeat_timer_inst (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .gate_strobe_o    (gate_strobe),
      .heartbeat_o      (heartbeat),
      .flash_pattern_o  (flash_pattern)
   );

   clk_freq_monitor clk_freq_monitor_inst (
      .clk_usb            (clk_usb),
      .reset              (reset),
      .dut_clk_i          (dut_clk_i),
      .gate_strobe_i      (gate_strobe),
      .extclk_limit_i     (cfg_i.extclk_limit),
      .monitor_disable_i  (cfg_i.monitor_disable),
      .extclk_freq_o      (extclk_freq_o),
      .extclk_change_o    (extclk_change)
   );

   adc_level_trigger adc_level_trigger_inst (
      .clk_usb               (clk_usb),
      .reset                 (reset),
      .adc_data_i            (adc_data_i),
      .data_source_select_i  (cfg_i.data_source_select),
      .trigger_level_i       (cfg_i.trigger_level),
      .armed_and_ready_i     (status_i.armed_and_ready),
      .trigger_adc_o         (trigger_adc_o)
   );

   board_outputs board_outputs_inst (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .led_select_i     (cfg_i.led_select),
      .status_i         (status_i),
      .heartbeat_i      (heartbeat),
      .flash_pattern_i  (flash_pattern),
      .extclk_change_i  (extclk_change),
      .gain_i           (cfg_i.gain),
      .led_armed_o      (led_armed_o),
      .led_capture_o    (led_capture_o),
      .amp_gain_o       (amp_gain_o)
   );

endmodule

//--- verilog/board_outputs.sv
`timescale 1ns/1ns

module board_outputs (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  scope_pkg::led_sel_t      led_select_i,
   input  scope_pkg::board_status_t status_i,
   input  logic                     heartbeat_i,
   input  logic                     flash_pattern_i,
   input  logic                     extclk_change_i,
   input  scope_pkg::gain_t         gain_i,
   output logic                     led_armed_o,
   output logic                     led_capture_o,
   output logic                     amp_gain_o
);

   import scope_pkg::*;

   logic [GAIN_W:0] pwm_acc;   // msb is the carry out

   // alarm overrides every select
   always_comb begin
      if (extclk_change_i) begin
         led_armed_o   = flash_pattern_i;
         led_capture_o = flash_pattern_i;
      end
      else if (led_select_i == 2'd1 || led_select_i == 2'd2) begin
         led_armed_o   = heartbeat_i;
         led_capture_o = heartbeat_i;
      end
      else if (led_select_i == 2'd3) begin
         led_armed_o   = heartbeat_i;
         led_capture_o = extclk_change_i;
      end
      else begin
         led_armed_o   = status_i.armed;
         led_capture_o = status_i.capture_active;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[GAIN_W-1:0]} + {1'b0, gain_i};
   end

   assign amp_gain_o = pwm_acc[GAIN_W];   // duty of gain/256

endmodule

//--- verilog/clk_freq_monitor.sv
`timescale 1ns/1ns

module clk_freq_monitor (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  logic                   dut_clk_i,
   input  logic                   gate_strobe_i,
   input  scope_pkg::freq_count_t extclk_limit_i,
   input  logic                   monitor_disable_i,
   output scope_pkg::freq_count_t extclk_freq_o,
   output logic                   extclk_change_o
);

   import scope_pkg::*;

   logic [1:0]  dut_sync;       // two-flop synchronizer
   logic        dut_prev;
   logic        dut_rise;
   freq_count_t edge_count;     // edges in the current window
   freq_count_t freq_delta;
   logic        measure_valid;  // a previous measurement exists

   assign dut_rise = dut_sync[1] & ~dut_prev;

   // absolute difference, new window against the latched one
   always_comb begin
      if (edge_count > extclk_freq_o)
         freq_delta = edge_count - extclk_freq_o;
      else
         freq_delta = extclk_freq_o - edge_count;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         dut_sync <= 2'b00;
         dut_prev <= 1'b0;
      end
      else begin
         dut_sync <= {dut_sync[0], dut_clk_i};
         dut_prev <= dut_sync[1];
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_count    <= '0;
         extclk_freq_o <= '0;
         measure_valid <= 1'b0;
      end
      else if (gate_strobe_i) begin
         extclk_freq_o <= edge_count;
         edge_count    <= {{(FREQ_W-1){1'b0}}, dut_rise};   // keep an edge on the strobe cycle
         measure_valid <= 1'b1;
      end
      else if (dut_rise) begin
         edge_count <= edge_count + 1'b1;
      end
   end

   // sticky change alarm
   always_ff @(posedge clk_usb) begin
      if (reset)
         extclk_change_o <= 1'b0;
      else if (monitor_disable_i)
         extclk_change_o <= 1'b0;
      else if (gate_strobe_i && measure_valid && (freq_delta > extclk_limit_i))
         extclk_change_o <= 1'b1;
   end

   change_cleared_by_disable: assert property (
      @(posedge clk_usb) disable iff (reset)
      monitor_disable_i |=> !extclk_change_o
   ) else $error("ERR extclk_change_o set after disable");

endmodule

//--- verilog/heartbeat_timer.sv
`timescale 1ns/1ns

module heartbeat_timer (
   input  logic clk_usb,
   input  logic reset,
   output logic gate_strobe_o,
   output logic heartbeat_o,
   output logic flash_pattern_o
);

   import scope_pkg::*;

   logic [TIMER_W-1:0] timer;
   logic               gate_bit_r;   // previous gate bit for edge detect

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer           <= '0;
         gate_bit_r      <= 1'b0;
         gate_strobe_o   <= 1'b0;
         flash_pattern_o <= 1'b0;
      end
      else begin
         timer         <= timer + 1'b1;   // free running
         gate_bit_r    <= timer[GATE_BIT];
         gate_strobe_o <= timer[GATE_BIT] & ~gate_bit_r;

         // flash only runs in the upper half of the timer period
         if (timer[TIMER_W-1])
            flash_pattern_o <= ~timer[FLASH_BIT];
      end
   end

   assign heartbeat_o = timer[HEARTBEAT_BIT];

   // the monitor relies on a single-cycle gate
   gate_strobe_single: assert property (
      @(posedge clk_usb) disable iff (reset)
      gate_strobe_o |=> !gate_strobe_o
   ) else $error("ERR gate_strobe_o high for two cycles");

endmodule

//--- verilog/scope_pkg.sv
package scope_pkg;

   // timer widths are cut down for simulation
   // hardware uses a 26-bit timer, gate on bit 23 and heartbeat on bit 24
   localparam int TIMER_W       = 10;
   localparam int GATE_BIT      = 5;   // gate period 2**(GATE_BIT+1) cycles
   localparam int HEARTBEAT_BIT = 8;
   localparam int FLASH_BIT     = 7;

   localparam int ADC_W  = 12;
   localparam int GAIN_W = 8;
   localparam int FREQ_W = 16;

   typedef logic [ADC_W-1:0]  adc_word_t;    // sample or trigger level
   typedef logic [FREQ_W-1:0] freq_count_t;  // edges per gate window
   typedef logic [GAIN_W-1:0] gain_t;        // pwm increment
   typedef logic [1:0]        led_sel_t;

   // host side settings, held as levels
   typedef struct packed {
      led_sel_t    led_select;
      gain_t       gain;
      adc_word_t   trigger_level;
      logic        data_source_select;   // 1 adc input, 0 ramp
      freq_count_t extclk_limit;
      logic        monitor_disable;
   } scope_cfg_t;

   // flags from the capture side
   typedef struct packed {
      logic armed;
      logic capture_active;
      logic armed_and_ready;
   } board_status_t;

endpackage
